//--- msu_pkg.sv
package msu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int reg_addr_w = 3;
  localparam int buf_addr_w = 14;
  localparam int buf_depth  = 16384;

  ////////////////////////////////////////////////////////////
  // Host register map
  ////////////////////////////////////////////////////////////
  // Read side
  localparam logic [reg_addr_w-1:0] reg_status = 3'd0;
  localparam logic [reg_addr_w-1:0] reg_data   = 3'd1;

  // Write side
  localparam logic [reg_addr_w-1:0] reg_seek0  = 3'd0;
  localparam logic [reg_addr_w-1:0] reg_seek1  = 3'd1;
  localparam logic [reg_addr_w-1:0] reg_seek2  = 3'd2;
  localparam logic [reg_addr_w-1:0] reg_seek3  = 3'd3;
  localparam logic [reg_addr_w-1:0] reg_track0 = 3'd4;
  localparam logic [reg_addr_w-1:0] reg_track1 = 3'd5;
  localparam logic [reg_addr_w-1:0] reg_volume = 3'd6;
  localparam logic [reg_addr_w-1:0] reg_ctrl   = 3'd7;

  // "S-MSU1" at read addresses 2 to 7
  localparam logic [7:0] id_bytes [6] = '{8'h53, 8'h2d, 8'h4d, 8'h53, 8'h55, 8'h31};

  localparam logic [3:0] status_low_nibble = 4'b0001;

  // Reset values and host strobe filtering
  localparam logic [buf_addr_w-1:0] buf_ptr_reset = 14'h1234;
  localparam int edge_quiet_samples = 5;
  localparam int addr_delay = 4;

endpackage

//--- msu_bus_if.sv
// Synchronized host access, one strobe pulse per qualified edge
interface msu_bus_if;

  logic [msu_pkg::reg_addr_w-1:0] rd_addr;
  logic [msu_pkg::reg_addr_w-1:0] wr_addr;
  logic [7:0]                     wr_data;
  logic                           rd_pulse;
  logic                           wr_pulse;

  modport src (
    output rd_addr,
    output wr_addr,
    output wr_data,
    output rd_pulse,
    output wr_pulse
  );

  modport dst (
    input rd_addr,
    input wr_addr,
    input wr_data,
    input rd_pulse,
    input wr_pulse
  );

endinterface

//--- msu_bus_sync.sv
module msu_bus_sync (
  input  logic                           clkin,
  input  logic                           arst_n,
  input  logic                           enable,
  input  logic [msu_pkg::reg_addr_w-1:0] reg_addr,
  input  logic [7:0]                     reg_data_in,
  input  logic                           reg_oe,
  input  logic                           reg_we,
  msu_bus_if.src                         bus
);

  logic [msu_pkg::edge_quiet_samples-1:0] en_hist;
  logic [msu_pkg::edge_quiet_samples:0]   oe_hist;
  logic [msu_pkg::edge_quiet_samples:0]   we_hist;
  logic [msu_pkg::reg_addr_w-1:0]         addr_pipe [msu_pkg::addr_delay];
  logic                                   en_ok;

  ////////////////////////////////////////////////////////////
  // Strobe sample histories
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      en_hist <= '1;
      oe_hist <= '0;
      we_hist <= '0;
    end else begin
      en_hist <= {en_hist[msu_pkg::edge_quiet_samples-2:0], enable};
      oe_hist <= {oe_hist[msu_pkg::edge_quiet_samples-1:0], reg_oe};
      we_hist <= {we_hist[msu_pkg::edge_quiet_samples-1:0], reg_we};
    end
  end

  // Enable as seen five samples back
  assign en_ok = en_hist[msu_pkg::edge_quiet_samples-1];

  // Rise only counts after a full run of low samples
  assign bus.rd_pulse = en_ok && (oe_hist == {{msu_pkg::edge_quiet_samples{1'b0}}, 1'b1});
  assign bus.wr_pulse = en_ok && (we_hist == {{msu_pkg::edge_quiet_samples{1'b0}}, 1'b1});

  ////////////////////////////////////////////////////////////
  // Register address delay
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    addr_pipe[0] <= reg_addr;
    for (int i = 1; i < msu_pkg::addr_delay; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  // Write decode taps early, read select at the end
  assign bus.wr_addr = addr_pipe[1];
  assign bus.rd_addr = addr_pipe[msu_pkg::addr_delay-1];
  assign bus.wr_data = reg_data_in;

  // Each host access yields exactly one pulse
  a_rd_pulse_single: assert property (
    @(posedge clkin) disable iff (!arst_n) bus.rd_pulse |=> !bus.rd_pulse
  );

  a_wr_pulse_single: assert property (
    @(posedge clkin) disable iff (!arst_n) bus.wr_pulse |=> !bus.wr_pulse
  );

endmodule

//--- msu_databuf.sv
module msu_databuf (
  input  logic                           clkin,
  input  logic [msu_pkg::buf_addr_w-1:0] pgm_address,
  input  logic [7:0]                     pgm_data,
  input  logic                           pgm_we,
  input  logic [msu_pkg::buf_addr_w-1:0] rd_address,
  output logic [7:0]                     rd_data
);

  logic [7:0] mem [msu_pkg::buf_depth];

  ////////////////////////////////////////////////////////////
  // Port A, controller fill
  ////////////////////////////////////////////////////////////
  // Write strobe is active low
  always_ff @(posedge clkin) begin
    if (!pgm_we) begin
      mem[pgm_address] <= pgm_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Port B, host read at the buffer pointer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_address];
  end

endmodule

//--- msu_regs.sv
module msu_regs (
  input  logic                           clkin,
  input  logic                           arst_n,
  msu_bus_if.dst                         bus,
  input  logic [7:0]                     buf_data,
  output logic [msu_pkg::buf_addr_w-1:0] buf_ptr,
  output logic [7:0]                     reg_data_out,
  output logic [6:0]                     status_out,
  output logic [7:0]                     volume_out,
  output logic                           volume_latch_out,
  output logic [31:0]                    addr_out,
  output logic [15:0]                    track_out,
  input  logic [5:0]                     status_reset_bits,
  input  logic [5:0]                     status_set_bits,
  input  logic                           status_reset_we,
  input  logic [msu_pkg::buf_addr_w-1:0] msu_address_ext,
  input  logic                           msu_address_ext_write
);

  logic [1:0] status_we_hist;
  logic [1:0] ext_write_hist;
  logic       status_rise;
  logic       ext_rise;

  logic       data_busy;
  logic       data_start;
  logic       audio_busy;
  logic       audio_start;
  logic       ctrl_start;
  logic       volume_latch;
  logic [1:0] audio_ctrl;
  logic [1:0] audio_status;

  ////////////////////////////////////////////////////////////
  // Controller strobe edge detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      status_we_hist <= '0;
      ext_write_hist <= '0;
    end else begin
      status_we_hist <= {status_we_hist[0], status_reset_we};
      ext_write_hist <= {ext_write_hist[0], msu_address_ext_write};
    end
  end

  assign status_rise = (status_we_hist == 2'b01);
  assign ext_rise    = (ext_write_hist == 2'b01);

  ////////////////////////////////////////////////////////////
  // Host write payload
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (bus.wr_pulse) begin
      case (bus.wr_addr)
        msu_pkg::reg_seek0:  addr_out[7:0]   <= bus.wr_data;
        msu_pkg::reg_seek1:  addr_out[15:8]  <= bus.wr_data;
        msu_pkg::reg_seek2:  addr_out[23:16] <= bus.wr_data;
        msu_pkg::reg_seek3:  addr_out[31:24] <= bus.wr_data;
        msu_pkg::reg_track0: track_out[7:0]  <= bus.wr_data;
        msu_pkg::reg_track1: track_out[15:8] <= bus.wr_data;
        msu_pkg::reg_volume: volume_out      <= bus.wr_data;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Status flags
  ////////////////////////////////////////////////////////////
  // Host write wins over a status update in the same cycle
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      data_busy    <= 1'b1;
      data_start   <= 1'b0;
      audio_busy   <= 1'b1;
      audio_start  <= 1'b0;
      ctrl_start   <= 1'b0;
      volume_latch <= 1'b0;
      audio_ctrl   <= '0;
      audio_status <= '0;
    end else if (bus.wr_pulse) begin
      case (bus.wr_addr)
        msu_pkg::reg_seek3: begin
          data_start <= 1'b1;
          data_busy  <= 1'b1;
        end
        msu_pkg::reg_track1: begin
          audio_start <= 1'b1;
          audio_busy  <= 1'b1;
        end
        msu_pkg::reg_volume: volume_latch <= 1'b1;
        msu_pkg::reg_ctrl: begin
          // Ignored while a track is still being set up
          if (!audio_busy) begin
            audio_ctrl <= bus.wr_data[1:0];
            ctrl_start <= 1'b1;
          end
        end
        default: ;
      endcase
    end else if (status_rise) begin
      audio_busy   <= (audio_busy | status_set_bits[5]) & ~status_reset_bits[5];
      data_busy    <= (data_busy | status_set_bits[4]) & ~status_reset_bits[4];
      audio_status <= (audio_status | status_set_bits[2:1]) & ~status_reset_bits[2:1];
      ctrl_start   <= (ctrl_start | status_set_bits[0]) & ~status_reset_bits[0];
      if (status_reset_bits[5]) begin
        audio_start <= 1'b0;
      end
      if (status_reset_bits[4]) begin
        data_start <= 1'b0;
      end
    end else begin
      volume_latch <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Buffer pointer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      buf_ptr <= msu_pkg::buf_ptr_reset;
    end else if (ext_rise) begin
      buf_ptr <= msu_address_ext;
    end else if (bus.rd_pulse && bus.rd_addr == msu_pkg::reg_data) begin
      buf_ptr <= buf_ptr + 1'b1;
    end
  end

  // Read data mux
  always_ff @(posedge clkin) begin
    case (bus.rd_addr)
      msu_pkg::reg_status: begin
        reg_data_out <= {data_busy, audio_busy, audio_status, msu_pkg::status_low_nibble};
      end
      msu_pkg::reg_data: reg_data_out <= buf_data;
      default:           reg_data_out <= msu_pkg::id_bytes[bus.rd_addr - 3'd2];
    endcase
  end

  assign volume_latch_out = volume_latch;

  assign status_out = {buf_ptr[msu_pkg::buf_addr_w-1],
                       audio_start,
                       data_start,
                       volume_latch,
                       audio_ctrl,
                       ctrl_start};

  // A control write during audio setup must not start anything
  a_ctrl_blocked: assert property (
    @(posedge clkin) disable iff (!arst_n)
    (bus.wr_pulse && bus.wr_addr == msu_pkg::reg_ctrl && audio_busy && !ctrl_start)
      |=> !ctrl_start
  );

endmodule

//--- msu_top.sv
module msu_top (
  input  logic        clkin,
  input  logic        arst_n,
  input  logic        enable,
  input  logic [13:0] pgm_address,
  input  logic [7:0]  pgm_data,
  input  logic        pgm_we,
  input  logic [2:0]  reg_addr,
  input  logic [7:0]  reg_data_in,
  output logic [7:0]  reg_data_out,
  input  logic        reg_oe,
  input  logic        reg_we,
  output logic [6:0]  status_out,
  output logic [7:0]  volume_out,
  output logic        volume_latch_out,
  output logic [31:0] addr_out,
  output logic [15:0] track_out,
  input  logic [5:0]  status_reset_bits,
  input  logic [5:0]  status_set_bits,
  input  logic        status_reset_we,
  input  logic [13:0] msu_address_ext,
  input  logic        msu_address_ext_write
);

  logic [msu_pkg::buf_addr_w-1:0] buf_ptr;
  logic [7:0]                     buf_data;

  msu_bus_if bus_if ();

  ////////////////////////////////////////////////////////////
  // Host side
  ////////////////////////////////////////////////////////////
  msu_bus_sync sync_inst (
    .clkin       (clkin),
    .arst_n      (arst_n),
    .enable      (enable),
    .reg_addr    (reg_addr),
    .reg_data_in (reg_data_in),
    .reg_oe      (reg_oe),
    .reg_we      (reg_we),
    .bus         (bus_if.src)
  );

  // Controller fills, host drains at the pointer
  msu_databuf databuf_inst (
    .clkin       (clkin),
    .pgm_address (pgm_address),
    .pgm_data    (pgm_data),
    .pgm_we      (pgm_we),
    .rd_address  (buf_ptr),
    .rd_data     (buf_data)
  );

  msu_regs regs_inst (
    .clkin                 (clkin),
    .arst_n                (arst_n),
    .bus                   (bus_if.dst),
    .buf_data              (buf_data),
    .buf_ptr               (buf_ptr),
    .reg_data_out          (reg_data_out),
    .status_out            (status_out),
    .volume_out            (volume_out),
    .volume_latch_out      (volume_latch_out),
    .addr_out              (addr_out),
    .track_out             (track_out),
    .status_reset_bits     (status_reset_bits),
    .status_set_bits       (status_set_bits),
    .status_reset_we       (status_reset_we),
    .msu_address_ext       (msu_address_ext),
    .msu_address_ext_write (msu_address_ext_write)
  );

endmodule

//--- tb_clock.sv
module tb_clock (
  output logic clkin,
  output logic arst_n
);

  localparam int half_period  = 10;
  localparam int reset_cycles = 8;

  initial begin
    clkin = 1'b0;
    forever #half_period clkin = ~clkin;
  end

  // Release away from the active edge
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clkin);
    @(negedge clkin);
    arst_n = 1'b1;
  end

endmodule

//--- msu_tb.sv
module msu_tb;

  localparam int margin = 10;

  logic        clkin;
  logic        arst_n;
  logic        enable;
  logic [13:0] pgm_address;
  logic [7:0]  pgm_data;
  logic        pgm_we;
  logic [2:0]  reg_addr;
  logic [7:0]  reg_data_in;
  logic [7:0]  reg_data_out;
  logic        reg_oe;
  logic        reg_we;
  logic [6:0]  status_out;
  logic [7:0]  volume_out;
  logic        volume_latch_out;
  logic [31:0] addr_out;
  logic [15:0] track_out;
  logic [5:0]  status_reset_bits;
  logic [5:0]  status_set_bits;
  logic        status_reset_we;
  logic [13:0] msu_address_ext;
  logic        msu_address_ext_write;

  // Reference model state
  logic [7:0]  m_mem [16384];
  logic [13:0] m_ptr;
  logic [31:0] m_seek;
  logic [15:0] m_track;
  logic [7:0]  m_volume;
  logic [1:0]  m_ctrl;
  logic [1:0]  m_astat;
  logic        m_dbusy;
  logic        m_abusy;
  logic        m_dstart;
  logic        m_astart;
  logic        m_cstart;

  logic [31:0] lfsr;
  logic        latch_seen;
  string       id_text = "S-MSU1";
  string       sig_names [5] = '{"reg_data_out", "status_out", "addr_out", "track_out",
                                 "volume_out"};

  tb_clock clock_inst (
    .clkin  (clkin),
    .arst_n (arst_n)
  );

  msu_top msu_top_inst (.*);

  // Latch pulse is one cycle wide so it is caught here
  always @(negedge clkin) begin
    if (volume_latch_out === 1'b1) begin
      latch_seen = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random source and expected values
  ////////////////////////////////////////////////////////////
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] exp_status_reg();
    return {24'd0, m_dbusy, m_abusy, m_astat, 4'b0001};
  endfunction

  function automatic logic [31:0] exp_status_out();
    return {25'd0, m_ptr[13], m_astart, m_dstart, 1'b0, m_ctrl, m_cstart};
  endfunction

  function automatic logic [31:0] observe(input int sel);
    case (sel)
      0:       return {24'd0, reg_data_out};
      1:       return {25'd0, status_out};
      2:       return addr_out;
      3:       return {16'd0, track_out};
      default: return {24'd0, volume_out};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking and bus tasks
  ////////////////////////////////////////////////////////////
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("tests failed");
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $fatal(1);
    end
  endtask

  task automatic settle(input int sel, input logic [31:0] exp);
    int n;
    n = 0;
    while (observe(sel) !== exp && n < margin) begin
      @(negedge clkin);
      n++;
    end
    check(sig_names[sel], observe(sel), exp);
  endtask

  task automatic select_reg(input logic [2:0] addr, input logic [31:0] exp);
    @(negedge clkin);
    reg_addr = addr;
    settle(0, exp);
  endtask

  // Address set up first, strobe 3 cycles high then 8 low
  task automatic host_access(input logic write, input logic [2:0] addr, input logic [7:0] data);
    @(negedge clkin);
    reg_addr    = addr;
    reg_data_in = data;
    repeat (5) @(negedge clkin);
    if (write) begin
      reg_we = 1'b1;
    end else begin
      reg_oe = 1'b1;
    end
    repeat (3) @(negedge clkin);
    reg_we = 1'b0;
    reg_oe = 1'b0;
    repeat (8) @(negedge clkin);
  endtask

  task automatic host_write(input logic [2:0] addr, input logic [7:0] data);
    host_access(1'b1, addr, data);
    case (addr)
      3'd0: m_seek[7:0] = data;
      3'd1: m_seek[15:8] = data;
      3'd2: m_seek[23:16] = data;
      3'd3: begin
        m_seek[31:24] = data;
        m_dstart = 1'b1;
        m_dbusy  = 1'b1;
      end
      3'd4: m_track[7:0] = data;
      3'd5: begin
        m_track[15:8] = data;
        m_astart = 1'b1;
        m_abusy  = 1'b1;
      end
      3'd6: m_volume = data;
      default: begin
        if (!m_abusy) begin
          m_ctrl   = data[1:0];
          m_cstart = 1'b1;
        end
      end
    endcase
  endtask

  task automatic host_read_data();
    host_access(1'b0, 3'd1, 8'd0);
    m_ptr = m_ptr + 14'd1;
    settle(0, {24'd0, m_mem[m_ptr]});
    settle(1, exp_status_out());
  endtask

  task automatic status_update(input logic [5:0] set, input logic [5:0] rst);
    @(negedge clkin);
    status_set_bits   = set;
    status_reset_bits = rst;
    status_reset_we   = 1'b1;
    repeat (3) @(negedge clkin);
    status_reset_we = 1'b0;
    m_abusy = (m_abusy | set[5]) & ~rst[5];
    m_dbusy = (m_dbusy | set[4]) & ~rst[4];
    m_astat = (m_astat | set[2:1]) & ~rst[2:1];
    m_cstart = (m_cstart | set[0]) & ~rst[0];
    if (rst[5]) begin
      m_astart = 1'b0;
    end
    if (rst[4]) begin
      m_dstart = 1'b0;
    end
    settle(1, exp_status_out());
    select_reg(3'd0, exp_status_reg());
  endtask

  task automatic program_byte(input logic [13:0] addr, input logic [7:0] data);
    @(negedge clkin);
    pgm_address = addr;
    pgm_data    = data;
    pgm_we      = 1'b0;
    @(negedge clkin);
    pgm_we = 1'b1;
    m_mem[addr] = data;
  endtask

  task automatic load_pointer(input logic [13:0] p);
    @(negedge clkin);
    msu_address_ext       = p;
    msu_address_ext_write = 1'b1;
    repeat (3) @(negedge clkin);
    msu_address_ext_write = 1'b0;
    m_ptr = p;
    settle(1, exp_status_out());
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    logic [13:0] p;
    logic [7:0]  d;
    int          n;
    enable = 1'b1;
    pgm_address = '0;
    pgm_data = '0;
    pgm_we = 1'b1;
    reg_addr = '0;
    reg_data_in = '0;
    reg_oe = 1'b0;
    reg_we = 1'b0;
    status_reset_bits = '0;
    status_set_bits = '0;
    status_reset_we = 1'b0;
    msu_address_ext = '0;
    msu_address_ext_write = 1'b0;
    lfsr = 32'hd6b6;
    latch_seen = 1'b0;
    m_ptr = 14'h1234;
    m_dbusy = 1'b1;
    m_abusy = 1'b1;
    m_dstart = 1'b0;
    m_astart = 1'b0;
    m_cstart = 1'b0;
    m_ctrl = '0;
    m_astat = '0;
    m_seek = '0;
    m_track = '0;
    m_volume = '0;

    n = 0;
    while (arst_n !== 1'b1 && n < 50) begin
      @(negedge clkin);
      n++;
    end
    if (arst_n !== 1'b1) begin
      $display("tests failed");
      $display("reset was never released");
      $fatal(1);
    end

    // Identification and reset status
    for (int i = 2; i < 8; i++) begin
      select_reg(3'(i), {24'd0, id_text[i-2]});
    end
    select_reg(3'd0, exp_status_reg());
    settle(1, exp_status_out());

    // Seek, track and volume
    for (int round = 0; round < 2; round++) begin
      for (int a = 0; a < 4; a++) begin
        r = random_bits(8);
        host_write(3'(a), r[7:0]);
      end
      settle(2, m_seek);
      settle(1, exp_status_out());
      r = random_bits(16);
      host_write(3'd4, r[7:0]);
      host_write(3'd5, r[15:8]);
      settle(3, {16'd0, m_track});
      settle(1, exp_status_out());
      latch_seen = 1'b0;
      r = random_bits(8);
      host_write(3'd6, r[7:0]);
      n = 0;
      while (!latch_seen && n < margin) begin
        @(negedge clkin);
        n++;
      end
      check("volume_latch_out", {31'd0, latch_seen}, 32'd1);
      settle(4, {24'd0, m_volume});
      settle(1, exp_status_out());
    end

    // Random status set and reset
    for (int k = 0; k < 8; k++) begin
      r = random_bits(12);
      status_update(r[5:0], r[11:6]);
    end

    // Buffer fill and streaming read across a pointer bit 13 change
    r = random_bits(6);
    p = {r[5], 8'hff, r[4:0]};
    for (int i = 0; i < 40; i++) begin
      r = random_bits(8);
      program_byte(p + 14'(i), r[7:0]);
    end
    load_pointer(p);
    select_reg(3'd1, {24'd0, m_mem[m_ptr]});
    for (int i = 1; i < 40; i++) begin
      host_read_data();
    end

    // Control write blocked while audio is busy
    status_update(6'b100000, 6'b000001);
    r = random_bits(8);
    d = {r[7:2], ~m_ctrl};
    host_write(3'd7, d);
    settle(1, exp_status_out());
    status_update(6'b000000, 6'b100000);
    host_write(3'd7, d);
    settle(1, exp_status_out());
    select_reg(3'd0, exp_status_reg());

    // Writes with enable low are dropped
    @(negedge clkin);
    enable = 1'b0;
    repeat (6) @(negedge clkin);
    latch_seen = 1'b0;
    for (int a = 0; a < 8; a++) begin
      r = random_bits(8);
      host_access(1'b1, 3'(a), r[7:0]);
    end
    enable = 1'b1;
    check("volume_latch_out", {31'd0, latch_seen}, 32'd0);
    settle(2, m_seek);
    settle(3, {16'd0, m_track});
    settle(4, {24'd0, m_volume});
    settle(1, exp_status_out());
    select_reg(3'd0, exp_status_reg());

    $display("all tests passed");
    $finish;
  end

endmodule

//--- filelist.f
msu_pkg.sv
msu_bus_if.sv
msu_bus_sync.sv
msu_databuf.sv
msu_regs.sv
msu_top.sv
tb_clock.sv
msu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= msu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
